// File: hw/vred_pkg.sv
package vred_pkg;

    localparam int VLEN_BITS   = 512;
    localparam int WORD_BITS   = 32;
    localparam int NUM_LANES   = VLEN_BITS / WORD_BITS;
    localparam int LANE_STAGES = 3;

    // most negative value per element, replicated over a word
    localparam logic [WORD_BITS-1:0] MAX_ID_8  = 32'h8080_8080;
    localparam logic [WORD_BITS-1:0] MAX_ID_16 = 32'h8000_8000;
    localparam logic [WORD_BITS-1:0] MAX_ID_32 = 32'h8000_0000;

    typedef enum logic {
        OP_SUM = 1'b0,
        OP_MAX = 1'b1
    } red_op_e;

    typedef enum logic [1:0] {
        SEW_8    = 2'b00,
        SEW_16   = 2'b01,
        SEW_32   = 2'b10,
        SEW_RSVD = 2'b11
    } sew_e;

    typedef enum logic [1:0] {
        LMUL_1    = 2'b00,
        LMUL_2    = 2'b01,
        LMUL_4    = 2'b10,
        LMUL_RSVD = 2'b11
    } lmul_e;

    typedef struct packed {
        red_op_e               op;
        sew_e                  sew;
        lmul_e                 lmul;
        logic [WORD_BITS-1:0]  scalar;
        logic [VLEN_BITS-1:0]  vec;
    } red_req_t;

    typedef struct packed {
        red_op_e               op;
        sew_e                  sew;
        logic [WORD_BITS-1:0]  scalar;
        logic                  squash;
        logic                  valid;
    } red_ctrl_t;

    // keep only the low SEW bits
    function automatic logic [WORD_BITS-1:0] sew_mask(sew_e sew, logic [WORD_BITS-1:0] x);
        case (sew)
            SEW_8:   return {24'b0, x[7:0]};
            SEW_16:  return {16'b0, x[15:0]};
            default: return x;
        endcase
    endfunction

    function automatic logic signed [WORD_BITS-1:0] sew_sext(sew_e sew,
                                                             logic [WORD_BITS-1:0] x);
        case (sew)
            SEW_8:   return {{24{x[7]}}, x[7:0]};
            SEW_16:  return {{16{x[15]}}, x[15:0]};
            default: return x;
        endcase
    endfunction

    // one reduction step on two elements held in the low SEW bits
    function automatic logic [WORD_BITS-1:0] elem_op(red_op_e op, sew_e sew,
                                                     logic [WORD_BITS-1:0] a,
                                                     logic [WORD_BITS-1:0] b);
        logic signed [WORD_BITS-1:0] sa;
        logic signed [WORD_BITS-1:0] sb;
        sa = sew_sext(sew, a);
        sb = sew_sext(sew, b);
        if (op == OP_SUM)
            return sew_mask(sew, a + b);
        return (sa >= sb) ? sew_mask(sew, a) : sew_mask(sew, b);
    endfunction

endpackage

// File: hw/vred_operand_fmt.sv
`timescale 1ns/1ps

module vred_operand_fmt (
    input  logic                              clk,
    input  logic                              nrst,
    input  vred_pkg::red_req_t                req,
    input  logic                              req_valid,
    input  logic                              advance,
    output logic                              req_ready,
    output vred_pkg::red_ctrl_t               fmt_ctrl,
    output logic [vred_pkg::VLEN_BITS-1:0]    fmt_words
);

    logic [vred_pkg::NUM_LANES-1:0]  word_active;
    logic [vred_pkg::WORD_BITS-1:0]  fill_word;
    logic [vred_pkg::VLEN_BITS-1:0]  words_d;
    logic [vred_pkg::VLEN_BITS-1:0]  words_q;
    vred_pkg::red_ctrl_t             ctrl_d;
    vred_pkg::red_ctrl_t             ctrl_q;

    assign req_ready = advance;

    // active words per LMUL: 4, 8 or 16
    always_comb
    begin
        case (req.lmul)
            vred_pkg::LMUL_1: word_active = 16'h000f;
            vred_pkg::LMUL_2: word_active = 16'h00ff;
            default:          word_active = 16'hffff;
        endcase
    end

    // identity value for the op
    always_comb
    begin
        if (req.op == vred_pkg::OP_SUM)
        begin
            fill_word = '0;
        end
        else
        begin
            case (req.sew)
                vred_pkg::SEW_8:  fill_word = vred_pkg::MAX_ID_8;
                vred_pkg::SEW_16: fill_word = vred_pkg::MAX_ID_16;
                default:          fill_word = vred_pkg::MAX_ID_32;
            endcase
        end
    end

    always_comb
    begin
        for (int i = 0; i < vred_pkg::NUM_LANES; i++)
        begin
            words_d[i*vred_pkg::WORD_BITS +: vred_pkg::WORD_BITS] =
                word_active[i] ? req.vec[i*vred_pkg::WORD_BITS +: vred_pkg::WORD_BITS]
                               : fill_word;
        end
    end

    always_comb
    begin
        ctrl_d.op     = req.op;
        ctrl_d.sew    = req.sew;
        ctrl_d.scalar = req.scalar;
        ctrl_d.squash = (req.sew == vred_pkg::SEW_RSVD) || (req.lmul == vred_pkg::LMUL_RSVD);
        ctrl_d.valid  = req_valid;
    end

    always_ff @(posedge clk)
    begin
        if (!nrst)
            ctrl_q.valid <= 1'b0;
        else if (advance)
            ctrl_q <= ctrl_d;
    end

    always_ff @(posedge clk)
    begin
        if (advance)
            words_q <= words_d;
    end

    assign fmt_ctrl  = ctrl_q;
    assign fmt_words = words_q;

endmodule

// File: hw/vred_lane.sv
`timescale 1ns/1ps

module vred_lane (
    input  logic                              clk,
    input  logic                              nrst,
    input  logic                              advance,
    input  vred_pkg::red_ctrl_t               ctrl_in,
    input  logic [vred_pkg::WORD_BITS-1:0]    word_in,
    output vred_pkg::red_ctrl_t               ctrl_out,
    output logic [vred_pkg::WORD_BITS-1:0]    lane_elem
);

    logic [vred_pkg::WORD_BITS-1:0]  byte_lo;
    logic [vred_pkg::WORD_BITS-1:0]  byte_hi;
    logic [vred_pkg::WORD_BITS-1:0]  elem_d;
    logic [vred_pkg::WORD_BITS-1:0]  elem_q;
    vred_pkg::red_ctrl_t             ctrl_q;

    // first level for 8-bit elements
    always_comb
    begin
        byte_lo = vred_pkg::elem_op(ctrl_in.op, vred_pkg::SEW_8,
                                    {24'b0, word_in[7:0]}, {24'b0, word_in[15:8]});
        byte_hi = vred_pkg::elem_op(ctrl_in.op, vred_pkg::SEW_8,
                                    {24'b0, word_in[23:16]}, {24'b0, word_in[31:24]});
    end

    always_comb
    begin
        case (ctrl_in.sew)
            vred_pkg::SEW_8:
            begin
                elem_d = vred_pkg::elem_op(ctrl_in.op, vred_pkg::SEW_8, byte_lo, byte_hi);
            end
            vred_pkg::SEW_16:
            begin
                elem_d = vred_pkg::elem_op(ctrl_in.op, vred_pkg::SEW_16,
                                           {16'b0, word_in[15:0]}, {16'b0, word_in[31:16]});
            end
            // a 32-bit word is already one element
            default:
            begin
                elem_d = word_in;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!nrst)
            ctrl_q.valid <= 1'b0;
        else if (advance)
            ctrl_q <= ctrl_in;
    end

    always_ff @(posedge clk)
    begin
        if (advance)
            elem_q <= elem_d;
    end

    assign ctrl_out  = ctrl_q;
    assign lane_elem = elem_q;

endmodule

// File: hw/vred_combine.sv
`timescale 1ns/1ps

module vred_combine (
    input  logic                                                   clk,
    input  logic                                                   nrst,
    input  vred_pkg::red_ctrl_t                                    ctrl_in,
    input  logic [vred_pkg::NUM_LANES*vred_pkg::WORD_BITS-1:0]     lane_elems,
    input  logic                                                   rsp_ready,
    output logic                                                   advance,
    output logic                                                   rsp_valid,
    output logic [vred_pkg::WORD_BITS-1:0]                         rsp_data
);

    localparam int W = vred_pkg::WORD_BITS;

    logic [W-1:0]  lvl1 [8];
    logic [W-1:0]  lvl2 [4];
    logic [W-1:0]  lvl3 [2];
    logic [W-1:0]  tree_res;
    logic [W-1:0]  fold_res;
    logic          rsp_valid_q;
    logic [W-1:0]  rsp_data_q;

    // pipeline moves unless a response is waiting
    assign advance = !rsp_valid_q || rsp_ready;

    // 16 -> 8 -> 4 -> 2 -> 1
    always_comb
    begin
        for (int i = 0; i < 8; i++)
        begin
            lvl1[i] = vred_pkg::elem_op(ctrl_in.op, ctrl_in.sew,
                                        lane_elems[(2*i)*W +: W],
                                        lane_elems[(2*i+1)*W +: W]);
        end
        for (int i = 0; i < 4; i++)
        begin
            lvl2[i] = vred_pkg::elem_op(ctrl_in.op, ctrl_in.sew, lvl1[2*i], lvl1[2*i+1]);
        end
        for (int i = 0; i < 2; i++)
        begin
            lvl3[i] = vred_pkg::elem_op(ctrl_in.op, ctrl_in.sew, lvl2[2*i], lvl2[2*i+1]);
        end
        tree_res = vred_pkg::elem_op(ctrl_in.op, ctrl_in.sew, lvl3[0], lvl3[1]);
    end

    // scalar joins last
    always_comb
    begin
        fold_res = vred_pkg::elem_op(ctrl_in.op, ctrl_in.sew, tree_res,
                                     vred_pkg::sew_mask(ctrl_in.sew, ctrl_in.scalar));
    end

    always_ff @(posedge clk)
    begin
        if (!nrst)
            rsp_valid_q <= 1'b0;
        else if (advance)
            rsp_valid_q <= ctrl_in.valid;
    end

    always_ff @(posedge clk)
    begin
        if (advance)
            rsp_data_q <= ctrl_in.squash ? '0 : fold_res;
    end

    assign rsp_valid = rsp_valid_q;
    assign rsp_data  = rsp_data_q;

endmodule

// File: hw/vred_unit.sv
`timescale 1ns/1ps

module vred_unit (
    input  logic                              clk,
    input  logic                              nrst,
    input  vred_pkg::red_req_t                req,
    input  logic                              req_valid,
    output logic                              req_ready,
    output logic                              rsp_valid,
    output logic [vred_pkg::WORD_BITS-1:0]    rsp_data,
    input  logic                              rsp_ready
);

    logic                                                  advance;
    vred_pkg::red_ctrl_t                                   fmt_ctrl;
    logic [vred_pkg::VLEN_BITS-1:0]                        fmt_words;
    vred_pkg::red_ctrl_t                                   lane_ctrl [vred_pkg::NUM_LANES];
    logic [vred_pkg::NUM_LANES*vred_pkg::WORD_BITS-1:0]    lane_elems;

    vred_operand_fmt i_fmt (
        .clk       (clk),
        .nrst      (nrst),
        .req       (req),
        .req_valid (req_valid),
        .advance   (advance),
        .req_ready (req_ready),
        .fmt_ctrl  (fmt_ctrl),
        .fmt_words (fmt_words)
    );

    // one lane per 32-bit word of the source
    for (genvar i = 0; i < vred_pkg::NUM_LANES; i++)
    begin : g_lane
        vred_lane i_lane (
            .clk       (clk),
            .nrst      (nrst),
            .advance   (advance),
            .ctrl_in   (fmt_ctrl),
            .word_in   (fmt_words[i*vred_pkg::WORD_BITS +: vred_pkg::WORD_BITS]),
            .ctrl_out  (lane_ctrl[i]),
            .lane_elem (lane_elems[i*vred_pkg::WORD_BITS +: vred_pkg::WORD_BITS])
        );
    end

    // all lanes carry the same control, lane 0 feeds the last stage
    vred_combine i_combine (
        .clk        (clk),
        .nrst       (nrst),
        .ctrl_in    (lane_ctrl[0]),
        .lane_elems (lane_elems),
        .rsp_ready  (rsp_ready),
        .advance    (advance),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data)
    );

endmodule

// File: testbench/vred_chk.sv
`timescale 1ns/1ps

module vred_chk (
    input logic                              clk,
    input logic                              nrst,
    input logic                              req_ready,
    input logic                              rsp_valid,
    input logic                              rsp_ready,
    input logic [vred_pkg::WORD_BITS-1:0]    rsp_data
);

    // a waiting response keeps its valid bit
    a_rsp_held: assert property (
        @(posedge clk) disable iff (!nrst)
        rsp_valid && !rsp_ready |=> rsp_valid
    )
    else
        $error("rsp_valid dropped before the response was accepted");

    a_data_stable: assert property (
        @(posedge clk) disable iff (!nrst)
        rsp_valid && !rsp_ready |=> $stable(rsp_data)
    )
    else
        $error("rsp_data changed while the response was stalled");

    // whole pipeline freezes behind a stalled response
    a_ready_stall: assert property (
        @(posedge clk) disable iff (!nrst)
        req_ready == !(rsp_valid && !rsp_ready)
    )
    else
        $error("req_ready does not match the response stall");

    a_reset_idle: assert property (
        @(posedge clk) !nrst |=> !rsp_valid
    )
    else
        $error("rsp_valid high in the cycle after reset");

endmodule

// File: testbench/vred_tb.sv
`timescale 1ns/1ps

module vred_tb;

    localparam int     NUM_REQ      = 2000;
    localparam int     CLK_PERIOD   = 4;
    localparam int     RESET_CYCLES = 10;
    localparam longint WATCHDOG_NS  = longint'(NUM_REQ * 40 + RESET_CYCLES) * CLK_PERIOD;

    logic                              clk;
    logic                              nrst;
    vred_pkg::red_req_t                req;
    logic                              req_valid;
    logic                              req_ready;
    logic                              rsp_valid;
    logic [vred_pkg::WORD_BITS-1:0]    rsp_data;
    logic                              rsp_ready;

    logic [31:0]  lfsr_state;
    logic [31:0]  bits;
    logic [31:0]  expect_q [$];
    logic [31:0]  exp_data;
    logic [31:0]  held_data;
    logic         stall_seen;
    logic         taken;
    int           accept_count;
    int           last_accept;
    int           rsp_count;

    vred_unit i_vred_unit (
        .clk       (clk),
        .nrst      (nrst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rsp_ready (rsp_ready)
    );

    bind vred_unit vred_chk i_vred_chk (
        .clk       (clk),
        .nrst      (nrst),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    // taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic vred_pkg::red_req_t random_req();
        vred_pkg::red_req_t r;
        logic [31:0] b;
        logic [31:0] neg;
        b = rand_bits(1);
        r.op = vred_pkg::red_op_e'(b[0]);
        b = rand_bits(4);
        r.sew = (b[3:0] == 4'd0) ? vred_pkg::SEW_RSVD : vred_pkg::sew_e'(2'(b[3:0] % 4'd3));
        b = rand_bits(4);
        r.lmul = (b[3:0] == 4'd0) ? vred_pkg::LMUL_RSVD : vred_pkg::lmul_e'(2'(b[3:0] % 4'd3));
        r.scalar = rand_bits(32);
        for (int i = 0; i < vred_pkg::NUM_LANES; i++)
            r.vec[i*vred_pkg::WORD_BITS +: vred_pkg::WORD_BITS] = rand_bits(32);
        // now and then every element negative, sometimes with a zero scalar on top
        b = rand_bits(3);
        if (b[2:1] == 2'd0)
        begin
            case (r.sew)
                vred_pkg::SEW_8:  neg = 32'h8080_8080;
                vred_pkg::SEW_16: neg = 32'h8000_8000;
                default:          neg = 32'h8000_0000;
            endcase
            for (int i = 0; i < vred_pkg::NUM_LANES; i++)
                r.vec[i*vred_pkg::WORD_BITS +: vred_pkg::WORD_BITS] |= neg;
            if (b[0])
                r.scalar = '0;
        end
        return r;
    endfunction

    // elements from the low 128*LMUL bits, folded onto the scalar
    function automatic logic [31:0] model_result(vred_pkg::red_req_t r);
        int                 sew_bits;
        int                 n_elems;
        int                 sh;
        logic [31:0]        mask;
        logic [31:0]        acc;
        logic [31:0]        e;
        logic signed [31:0] se;
        logic signed [31:0] sa;
        if (r.sew == vred_pkg::SEW_RSVD || r.lmul == vred_pkg::LMUL_RSVD)
            return '0;
        sew_bits = 8 << int'(r.sew);
        n_elems = (128 << int'(r.lmul)) / sew_bits;
        sh = 32 - sew_bits;
        mask = 32'hffff_ffff >> sh;
        acc = r.scalar & mask;
        for (int i = 0; i < n_elems; i++)
        begin
            e = 32'(r.vec >> (i * sew_bits)) & mask;
            se = e << sh;
            sa = acc << sh;
            if (r.op == vred_pkg::OP_SUM)
                acc = (acc + e) & mask;
            else if (se > sa)
                acc = e;
        end
        return acc;
    endfunction

    // back-to-back requests with no stall
    task automatic check_streaming();
        rsp_ready = 1'b1;
        req_valid = 1'b1;
        req = random_req();
        for (int i = 0; i < 8; i++)
        begin
            @(negedge clk);
            assert (rsp_valid == (i >= vred_pkg::LANE_STAGES - 1))
            else
            begin
                $display("Fail rsp_valid: %h in streaming cycle %0d", rsp_valid, i);
                abort_run();
            end
            req = random_req();
        end
    endtask

    always @(posedge clk)
    begin
        if (nrst)
        begin
            assert (req_ready == !(rsp_valid && !rsp_ready))
            else
            begin
                $display("Fail req_ready: got %h, expected %h",
                         req_ready, !(rsp_valid && !rsp_ready));
                abort_run();
            end
            if (stall_seen)
            begin
                assert (rsp_valid)
                else
                begin
                    $display("rsp_valid dropped while its response was stalled");
                    abort_run();
                end
                assert (rsp_data == held_data)
                else
                begin
                    $display("Fail rsp_data: %h changed to %h during a stall", held_data, rsp_data);
                    abort_run();
                end
            end
            if (rsp_valid && rsp_ready)
            begin
                assert (expect_q.size() != 0)
                else
                begin
                    $display("a response arrived with no request outstanding");
                    abort_run();
                end
                exp_data = expect_q.pop_front();
                assert (rsp_data == exp_data)
                else
                begin
                    $display("Fail rsp_data: got %h, expected %h", rsp_data, exp_data);
                    abort_run();
                end
                rsp_count <= rsp_count + 1;
            end
            if (req_valid && req_ready)
            begin
                expect_q.push_back(model_result(req));
                accept_count <= accept_count + 1;
            end
        end
        else
        begin
            accept_count <= 0;
            rsp_count <= 0;
        end
        stall_seen <= nrst && rsp_valid && !rsp_ready;
        held_data <= rsp_data;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout, the responses stopped before all requests were answered");
        abort_run();
    end

    initial
    begin
        lfsr_state = 32'h2d94_a3c1;
        nrst = 1'b0;
        req = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        nrst = 1'b1;
        @(negedge clk);
        check_streaming();
        last_accept = accept_count;
        while (rsp_count < NUM_REQ)
        begin
            @(negedge clk);
            taken = (accept_count != last_accept);
            last_accept = accept_count;
            rsp_ready = (rand_bits(2) != 32'd0);
            if (accept_count >= NUM_REQ)
            begin
                req_valid = 1'b0;
            end
            else if (!req_valid || taken)
            begin
                bits = rand_bits(1);
                req_valid = bits[0];
                req = random_req();
            end
        end
        // stray responses would hit the empty queue here
        rsp_ready = 1'b1;
        req_valid = 1'b0;
        repeat (8) @(negedge clk);
        if (expect_q.size() == 0)
        begin
            $display("test passed");
            $finish;
        end
        else
        begin
            $display("%0d expected responses never arrived", expect_q.size());
            abort_run();
        end
    end

endmodule

// File: filelist.f
hw/vred_pkg.sv
hw/vred_operand_fmt.sv
hw/vred_lane.sv
hw/vred_combine.sv
hw/vred_unit.sv
testbench/vred_chk.sv
testbench/vred_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= vred_tb
FILELIST  ?= filelist.f
SEED_ARGS ?= +verilator+seed+1
BUILD_DIR ?= build

VFLAGS = --timing --assert --top-module $(TOP) -f $(FILELIST)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

sim:
	$(VERILATOR) --binary $(VFLAGS) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SEED_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "test passed"

clean:
	rm -rf $(BUILD_DIR)
